// ==== mem_pkg.sv ====
package mem_pkg;

  // ==========================================================================
  // data and address types
  // ==========================================================================

  typedef logic [31:0]  word_t;       // cpu data word.
  typedef logic [127:0] block_t;      // cache block, dram transfer unit.
  typedef logic [31:0]  byte_addr_t;  // cpu byte address.

  // ==========================================================================
  // dram timing and geometry
  // ==========================================================================

  // cycles of held enable before mem_ready.
  localparam int DRAM_LATENCY = 4;

  localparam int BLOCK_BYTES = 16;    // bytes per block.

endpackage

// ==== cache_pkg.sv ====
package cache_pkg;

  // ==========================================================================
  // block geometry
  // ==========================================================================

  // words held in one block.
  localparam int WORDS_PER_BLOCK = (mem_pkg::BLOCK_BYTES * 8) / $bits(mem_pkg::word_t);

  // byte offset inside a block.
  localparam int OFFSET_BITS = $clog2(mem_pkg::BLOCK_BYTES);

  // ==========================================================================
  // cpu request and controller state
  // ==========================================================================

  typedef struct packed {
    logic                we;     // 1 for a store.
    mem_pkg::byte_addr_t addr;
    mem_pkg::word_t      wdata;  // store data, ignored on loads.
  } cpu_req_t;

  typedef enum logic [2:0] {
    idle,
    lookup,
    write_back,  // dirty victim out to dram.
    allocate,    // refill from dram.
    respond
  } ctrl_state_t;

endpackage

// ==== dram_model.sv ====
`timescale 1ns/1ps

module dram_model #(
  parameter int MEM_SIZE        = 64 * 1024,
  parameter int BLOCK_ADDR_BITS = 12
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wren,
  input  logic                       rden,
  input  logic [BLOCK_ADDR_BITS-1:0] addr,      // block number.
  input  mem_pkg::block_t            data_in,
  output mem_pkg::block_t            data_out,
  output logic                       mem_ready
);

  localparam int OFF_BITS  = $clog2(mem_pkg::BLOCK_BYTES);
  localparam int ADDR_BITS = BLOCK_ADDR_BITS + OFF_BITS;
  localparam int CNT_BITS  = $clog2(mem_pkg::DRAM_LATENCY + 1);

  logic [7:0]           mem [MEM_SIZE];
  logic [ADDR_BITS-1:0] base_addr;
  logic [CNT_BITS-1:0]  counter;

  initial begin
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem[i] = 8'h00;
    end
  end

  assign base_addr = {addr, {OFF_BITS{1'b0}}};  // first byte of the block.

  // ==========================================================================
  // latency counter
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      counter   <= '0;
      mem_ready <= 1'b0;
    end else if (counter == CNT_BITS'(mem_pkg::DRAM_LATENCY - 1)) begin
      counter   <= '0;
      mem_ready <= 1'b1;                        // single cycle pulse.
    end else if (wren || rden) begin
      counter   <= counter + 1'b1;
      mem_ready <= 1'b0;
    end else begin
      counter   <= '0;
      mem_ready <= 1'b0;
    end
  end

  // ==========================================================================
  // block access, little endian byte order
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (wren && !rden) begin
      for (int b = 0; b < mem_pkg::BLOCK_BYTES; b++) begin
        mem[base_addr + ADDR_BITS'(b)] <= data_in[8*b +: 8];
      end
    end else if (rden && !wren) begin
      for (int b = 0; b < mem_pkg::BLOCK_BYTES; b++) begin
        data_out[8*b +: 8] <= mem[base_addr + ADDR_BITS'(b)];
      end
    end
  end

endmodule

// ==== cache_tag_store.sv ====
`timescale 1ns/1ps

module cache_tag_store #(
  parameter int NUM_LINES = 64,
  parameter int TAG_BITS  = 6
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [$clog2(NUM_LINES)-1:0] index,
  input  logic [TAG_BITS-1:0]          tag,
  input  logic                         tag_wr,
  input  logic                         new_valid,
  input  logic                         new_dirty,
  output logic                         hit,
  output logic                         victim_dirty,
  output logic [TAG_BITS-1:0]          victim_tag
);

  logic [TAG_BITS-1:0]  tag_mem [NUM_LINES];
  logic [NUM_LINES-1:0] valid;
  logic [NUM_LINES-1:0] dirty;

  // status bits.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
    end else if (tag_wr) begin
      valid[index] <= new_valid;
      dirty[index] <= new_dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wr) begin
      tag_mem[index] <= tag;
    end
  end

  assign victim_tag   = tag_mem[index];
  assign hit          = valid[index] && (victim_tag == tag);
  assign victim_dirty = valid[index] && dirty[index];  // needs write back.

endmodule

// ==== cache_data_store.sv ====
`timescale 1ns/1ps

module cache_data_store #(
  parameter int NUM_LINES = 64
) (
  input  logic                                          clk,
  input  logic [$clog2(NUM_LINES)-1:0]                  index,
  input  logic                                          word_wr,
  input  logic [$clog2(cache_pkg::WORDS_PER_BLOCK)-1:0] word_sel,
  input  mem_pkg::word_t                                wdata,
  input  logic                                          fill_wr,
  input  mem_pkg::block_t                               fill_data,
  output mem_pkg::block_t                               line
);

  localparam int WORD_W = $bits(mem_pkg::word_t);

  mem_pkg::block_t data_mem [NUM_LINES];
  mem_pkg::block_t merged;

  assign line = data_mem[index];

  // current line with one word replaced.
  always_comb begin
    merged = line;
    merged[word_sel*WORD_W +: WORD_W] = wdata;
  end

  always_ff @(posedge clk) begin
    if (fill_wr) begin
      data_mem[index] <= fill_data;   // refill takes the whole block.
    end else if (word_wr) begin
      data_mem[index] <= merged;
    end
  end

endmodule

// ==== cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller #(
  parameter int NUM_LINES = 64,
  parameter int TAG_BITS  = 6
) (
  input  logic                                          clk,
  input  logic                                          rst,
  // cpu side
  input  logic                                          req,
  input  cache_pkg::cpu_req_t                           req_data,
  output logic                                          done,
  output mem_pkg::word_t                                rdata,
  // tag store
  output logic [$clog2(NUM_LINES)-1:0]                  index,
  output logic [TAG_BITS-1:0]                           tag,
  output logic                                          tag_wr,
  output logic                                          new_valid,
  output logic                                          new_dirty,
  input  logic                                          hit,
  input  logic                                          victim_dirty,
  input  logic [TAG_BITS-1:0]                           victim_tag,
  // data store
  output logic                                          word_wr,
  output logic [$clog2(cache_pkg::WORDS_PER_BLOCK)-1:0] word_sel,
  output mem_pkg::word_t                                wdata,
  output logic                                          fill_wr,
  output mem_pkg::block_t                               fill_data,
  input  mem_pkg::block_t                               line,
  // dram side
  output logic                                          wren,
  output logic                                          rden,
  output logic [TAG_BITS+$clog2(NUM_LINES)-1:0]         mem_addr,
  output mem_pkg::block_t                               mem_wdata,
  input  logic                                          mem_ready,
  input  mem_pkg::block_t                               mem_rdata
);

  localparam int INDEX_BITS = $clog2(NUM_LINES);
  localparam int SEL_BITS   = $clog2(cache_pkg::WORDS_PER_BLOCK);
  localparam int BYTE_BITS  = cache_pkg::OFFSET_BITS - SEL_BITS;
  localparam int WORD_W     = $bits(mem_pkg::word_t);

  cache_pkg::ctrl_state_t state;
  cache_pkg::cpu_req_t    req_q;
  logic                   gap_q;       // dram enable must drop for a cycle.
  logic                   write_hit;
  logic                   fill_done;

  // ==========================================================================
  // state machine
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cache_pkg::idle;
      gap_q <= 1'b0;
    end else begin
      gap_q <= mem_ready;
      case (state)
        cache_pkg::idle: begin
          if (req) begin
            state <= cache_pkg::lookup;
          end
        end
        cache_pkg::lookup: begin
          if (hit) begin
            state <= cache_pkg::respond;
          end else if (victim_dirty) begin
            state <= cache_pkg::write_back;
          end else begin
            state <= cache_pkg::allocate;
          end
        end
        cache_pkg::write_back: begin
          if (wren && mem_ready) begin
            state <= cache_pkg::allocate;
          end
        end
        cache_pkg::allocate: begin
          if (fill_done) begin
            state <= cache_pkg::lookup;   // retry, hits now.
          end
        end
        default: begin
          state <= cache_pkg::idle;       // respond lasts one cycle.
        end
      endcase
    end
  end

  // request is held by the cpu, but it is registered here.
  always_ff @(posedge clk) begin
    if (state == cache_pkg::idle && req) begin
      req_q <= req_data;
    end
  end

  // ==========================================================================
  // address split and store control
  // ==========================================================================

  assign index    = req_q.addr[cache_pkg::OFFSET_BITS +: INDEX_BITS];
  assign tag      = req_q.addr[cache_pkg::OFFSET_BITS + INDEX_BITS +: TAG_BITS];
  assign word_sel = req_q.addr[BYTE_BITS +: SEL_BITS];
  assign wdata    = req_q.wdata;

  assign write_hit = (state == cache_pkg::lookup) && hit && req_q.we;
  assign fill_done = (state == cache_pkg::allocate) && rden && mem_ready;

  assign tag_wr    = write_hit || fill_done;
  assign new_valid = 1'b1;
  assign new_dirty = write_hit;          // clean after refill.
  assign word_wr   = write_hit;
  assign fill_wr   = fill_done;
  assign fill_data = mem_rdata;

  // ==========================================================================
  // dram and cpu outputs
  // ==========================================================================

  assign wren      = (state == cache_pkg::write_back) && !gap_q;
  assign rden      = (state == cache_pkg::allocate) && !gap_q;
  assign mem_addr  = (state == cache_pkg::write_back) ? {victim_tag, index} : {tag, index};
  assign mem_wdata = line;                // victim block.

  assign done  = (state == cache_pkg::respond);
  assign rdata = line[word_sel*WORD_W +: WORD_W];

endmodule

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
  parameter int MEM_SIZE   = 64 * 1024,
  parameter int CACHE_SIZE = 1024
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                req,
  input  cache_pkg::cpu_req_t req_data,
  output logic                done,
  output mem_pkg::word_t      rdata
);

  localparam int NUM_LINES       = CACHE_SIZE / mem_pkg::BLOCK_BYTES;
  localparam int INDEX_BITS      = $clog2(NUM_LINES);
  localparam int BLOCK_ADDR_BITS = $clog2(MEM_SIZE) - cache_pkg::OFFSET_BITS;
  localparam int TAG_BITS        = BLOCK_ADDR_BITS - INDEX_BITS;
  localparam int SEL_BITS        = $clog2(cache_pkg::WORDS_PER_BLOCK);

  // ==========================================================================
  // interconnect
  // ==========================================================================

  logic [INDEX_BITS-1:0]      index;
  logic [TAG_BITS-1:0]        tag;
  logic                       tag_wr;
  logic                       new_valid;
  logic                       new_dirty;
  logic                       hit;
  logic                       victim_dirty;
  logic [TAG_BITS-1:0]        victim_tag;
  logic                       word_wr;
  logic [SEL_BITS-1:0]        word_sel;
  mem_pkg::word_t             wdata;
  logic                       fill_wr;
  mem_pkg::block_t            fill_data;
  mem_pkg::block_t            line;
  logic                       wren;
  logic                       rden;
  logic [BLOCK_ADDR_BITS-1:0] mem_addr;
  mem_pkg::block_t            mem_wdata;
  logic                       mem_ready;
  mem_pkg::block_t            mem_rdata;

  cache_controller #(
    .NUM_LINES (NUM_LINES),
    .TAG_BITS  (TAG_BITS)
  ) u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .req_data     (req_data),
    .done         (done),
    .rdata        (rdata),
    .index        (index),
    .tag          (tag),
    .tag_wr       (tag_wr),
    .new_valid    (new_valid),
    .new_dirty    (new_dirty),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .word_wr      (word_wr),
    .word_sel     (word_sel),
    .wdata        (wdata),
    .fill_wr      (fill_wr),
    .fill_data    (fill_data),
    .line         (line),
    .wren         (wren),
    .rden         (rden),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata)
  );

  cache_tag_store #(
    .NUM_LINES (NUM_LINES),
    .TAG_BITS  (TAG_BITS)
  ) u_tags (
    .clk          (clk),
    .rst          (rst),
    .index        (index),
    .tag          (tag),
    .tag_wr       (tag_wr),
    .new_valid    (new_valid),
    .new_dirty    (new_dirty),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  cache_data_store #(
    .NUM_LINES (NUM_LINES)
  ) u_data (
    .clk       (clk),
    .index     (index),
    .word_wr   (word_wr),
    .word_sel  (word_sel),
    .wdata     (wdata),
    .fill_wr   (fill_wr),
    .fill_data (fill_data),
    .line      (line)
  );

  dram_model #(
    .MEM_SIZE        (MEM_SIZE),
    .BLOCK_ADDR_BITS (BLOCK_ADDR_BITS)
  ) u_dram (
    .clk       (clk),
    .rst       (rst),
    .wren      (wren),
    .rden      (rden),
    .addr      (mem_addr),
    .data_in   (mem_wdata),
    .data_out  (mem_rdata),
    .mem_ready (mem_ready)
  );

endmodule

// ==== cache_properties.sv ====
`timescale 1ns/1ps

module cache_properties (
  input logic clk,
  input logic rst,
  input logic req,
  input logic done,
  input logic wren,
  input logic rden
);

  // dram enables are exclusive.
  a_enables: assert property (@(posedge clk) disable iff (rst) !(wren && rden))
    else $error("wren and rden high in the same cycle");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done high for two cycles in a row");

  // cpu holds req until done.
  a_done_req: assert property (@(posedge clk) disable iff (rst) done |-> req)
    else $error("done high while req is low");

endmodule

bind cache_controller cache_properties u_props (
  .clk  (clk),
  .rst  (rst),
  .req  (req),
  .done (done),
  .wren (wren),
  .rden (rden)
);

// ==== cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

  localparam int MEM_SIZE     = 64 * 1024;
  localparam int CACHE_SIZE   = 1024;
  localparam int CLK_PERIOD   = 8;
  localparam int MISS_BOUND   = 40;   // cycle bound for one access.
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_ACCESSES = 4 + 5 + 4 + 2 + NUM_RANDOM;
  localparam int SEED         = 32'hc9bf;

  logic                clk;
  logic                rst;
  logic                req;
  cache_pkg::cpu_req_t req_data;
  logic                done;
  mem_pkg::word_t      rdata;

  mem_pkg::word_t ref_mem [MEM_SIZE / 4];  // word level model of dram.
  int             errors;
  int             last_cycles;

  cache_top #(
    .MEM_SIZE   (MEM_SIZE),
    .CACHE_SIZE (CACHE_SIZE)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_data (req_data),
    .done     (done),
    .rdata    (rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==========================================================================
  // one cpu access entered and left 1 ns after a rising edge
  // ==========================================================================

  task automatic access(input logic we, input mem_pkg::byte_addr_t addr,
                        input mem_pkg::word_t wdata);
    int cycles;
    cycles = 0;
    req            = 1'b1;
    req_data.we    = we;
    req_data.addr  = addr;
    req_data.wdata = wdata;
    do begin
      @(negedge clk);
      cycles++;
    end while (!done && cycles <= MISS_BOUND);
    last_cycles = cycles - 1;  // counted from the edge that samples req.
    if (!done) begin
      errors++;
      $display("no done for access to %h within %0d cycles", addr, MISS_BOUND);
    end else if (we) begin
      ref_mem[addr[15:2]] = wdata;
    end else if (rdata !== ref_mem[addr[15:2]]) begin
      errors++;
      $display("error: t=%0t rdata at %h got %h expected %h",
               $time, addr, rdata, ref_mem[addr[15:2]]);
    end
    @(posedge clk);
    #1;
    req = 1'b0;
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================

  task automatic cold_reads();
    access(1'b0, 32'h0000_0000, 32'h0);
    access(1'b0, 32'h0000_0004, 32'h0);
    access(1'b0, 32'h0000_3a10, 32'h0);
    access(1'b0, 32'h0000_fffc, 32'h0);
  endtask

  // neighbors of the written word must stay zero.
  task automatic write_readback();
    access(1'b1, 32'h0000_0208, 32'hdead_beef);
    for (int i = 0; i < 4; i++) begin
      access(1'b0, 32'h0000_0200 + i * 4, 32'h0);
    end
  endtask

  task automatic dirty_eviction();
    access(1'b1, 32'h0000_0140, 32'h1111_2222);
    access(1'b1, 32'h0000_0140 + CACHE_SIZE, 32'h3333_4444);  // same index.
    access(1'b0, 32'h0000_0140, 32'h0);
    access(1'b0, 32'h0000_0140 + CACHE_SIZE, 32'h0);
  endtask

  task automatic hit_latency();
    access(1'b0, 32'h0000_0208, 32'h0);
    access(1'b0, 32'h0000_0208, 32'h0);
    if (last_cycles != 2) begin
      errors++;
      $display("error: t=%0t done latency got %0d expected 2", $time, last_cycles);
    end
  endtask

  // 4 KiB window over a 1 KiB cache, so lines conflict often.
  task automatic random_traffic();
    logic [31:0] rnd;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd = $urandom;
      access(rnd[10], 32'h0000_4000 + ((rnd % 1024) << 2), $urandom);
    end
  endtask

  // ==========================================================================
  // run control
  // ==========================================================================

  initial begin
    #((4 + NUM_ACCESSES * MISS_BOUND) * CLK_PERIOD);
    $display("watchdog expired, tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int seed_val;
    clk         = 1'b0;
    rst         = 1'b1;
    req         = 1'b0;
    req_data    = '0;
    errors      = 0;
    last_cycles = 0;
    seed_val    = $urandom(SEED);
    for (int i = 0; i < MEM_SIZE / 4; i++) begin
      ref_mem[i] = 32'h0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    cold_reads();
    write_readback();
    dirty_eviction();
    hit_latency();
    random_traffic();
    $display("tests done, %0d errors over %0d accesses", errors, NUM_ACCESSES);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
mem_pkg.sv
cache_pkg.sv
dram_model.sv
cache_tag_store.sv
cache_data_store.sv
cache_controller.sv
cache_top.sv
cache_properties.sv
cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cache_tb --Mdir obj_dir -o cache_tb_sim -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cache_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
